//--- Bender.yml
package:
  name: pipe

sources:
  - hw/pipe_pkg.sv
  - hw/pipe_regfile.sv
  - hw/hazard_bypass.sv
  - hw/id_stage.sv
  - hw/ex_stage.sv
  - hw/wb_stage.sv
  - hw/pipe_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/pipe_tb.sv

//--- bench/pipe_model.svh
// In-order architectural model; needs pipe_pkg imported and fail_run defined in the includer
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// Architectural register file, r0 never written
logic [XLEN-1:0]    arch_rf [NREGS];

// Expected retirements in program order
logic [RADDR_W-1:0] exp_rd_q    [$];
logic [XLEN-1:0]    exp_data_q  [$];
logic [XLEN-1:0]    exp_addr_q  [$];
logic               exp_load_q  [$];
int                 exp_cycle_q [$];

// Memory image, rotate left by 3 then XOR
function automatic logic [XLEN-1:0] mem_data(input logic [XLEN-1:0] addr);
  return {addr[XLEN-4:0], addr[XLEN-1:XLEN-3]} ^ 16'hA5C3;
endfunction

task automatic clear_arch_state();
  foreach (arch_rf[i]) begin
    arch_rf[i] = '0;
  end
endtask

// Executes one accepted instruction against the architectural state
task automatic accept_instr(input logic [INSTR_W-1:0] instr, input int cyc);
  logic [1:0]         op;
  logic [RADDR_W-1:0] rd;
  logic [RADDR_W-1:0] rs1;
  logic [RADDR_W-1:0] rs2;
  logic [XLEN-1:0]    imm;
  logic [XLEN-1:0]    addr;
  logic [XLEN-1:0]    result;
  op   = instr[OP_LSB +: 2];
  rd   = instr[RD_LSB +: RADDR_W];
  rs1  = instr[RS1_LSB +: RADDR_W];
  rs2  = instr[RS2_LSB +: RADDR_W];
  // Zero-extended immediate
  imm  = instr[IMM_LSB +: (RS2_LSB - IMM_LSB)];
  addr = '0;
  case (op)
    OP_ADD:  result = arch_rf[rs1] + arch_rf[rs2];
    OP_SUB:  result = arch_rf[rs1] - arch_rf[rs2];
    OP_LOAD: begin
      addr   = arch_rf[rs1] + imm;
      result = mem_data(addr);
    end
    default: result = '0;
  endcase
  // NOP retires with rd zero
  if (op == OP_NOP) begin
    rd = '0;
  end
  exp_rd_q.push_back(rd);
  exp_data_q.push_back(result);
  exp_addr_q.push_back(addr);
  exp_load_q.push_back(op == OP_LOAD);
  exp_cycle_q.push_back(cyc);
  // r0 stays zero even though the write retires
  if ((op != OP_NOP) && (rd != '0)) begin
    arch_rf[rd] = result;
  end
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    fail_run($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                       $time, name, exp, act));
  end
endtask

`endif

//--- bench/pipe_tb.sv
// Self-checking bench for pipe_top; fixed-seed random program, load data is a function of address
`default_nettype none

module pipe_tb;
  import pipe_pkg::*;

  localparam int NUM_INSTR  = 400;
  // Worst case about 8 cycles per instruction plus reset and drain
  localparam int MAX_CYCLES = NUM_INSTR * 8 + 100;

  logic               clk_i = 1'b0;
  logic               arst_n_i;
  logic               instr_valid_i;
  logic [INSTR_W-1:0] instr_i;
  logic               instr_ready_o;
  logic               dmem_req_o;
  logic [XLEN-1:0]    dmem_addr_o;
  logic               dmem_rvalid_i;
  logic [XLEN-1:0]    dmem_rdata_i;
  logic               retire_valid_o;
  logic [RADDR_W-1:0] retire_rd_o;
  logic [XLEN-1:0]    retire_data_o;

  integer             seed = 37970;
  logic               run;
  logic               xfer_seen;
  logic [INSTR_W-1:0] next_instr;
  bit                 mem_busy;
  int                 mem_wait;
  int                 cycle;
  int                 last_bp_cycle;
  int                 n_gen;
  int                 n_accepted;
  int                 n_retired;

  `include "pipe_model.svh"

  pipe_top u_pipe_top (
    .clk_i, .arst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
    .dmem_req_o, .dmem_addr_o, .dmem_rvalid_i, .dmem_rdata_i,
    .retire_valid_o, .retire_rd_o, .retire_data_o
  );

  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Mostly r0..r3 so dependencies are frequent
  task automatic pick_reg(output logic [RADDR_W-1:0] r);
    if (($random(seed) & 3) != 0) begin
      r = {1'b0, 2'($random(seed))};
    end else begin
      r = 3'($random(seed));
    end
  endtask

  task automatic build_instr(output logic [INSTR_W-1:0] w);
    logic [RADDR_W-1:0] r;
    w = '0;
    w[OP_LSB +: 2] = 2'($random(seed));
    pick_reg(r);
    w[RD_LSB +: RADDR_W] = r;
    pick_reg(r);
    w[RS1_LSB +: RADDR_W] = r;
    pick_reg(r);
    w[RS2_LSB +: RADDR_W] = r;
    w[IMM_LSB +: (RS2_LSB - IMM_LSB)] = 5'($random(seed));
  endtask

  // Answers a held request after 0 to 3 cycles, one rvalid per load
  task automatic respond_memory();
    dmem_rvalid_i = 1'b0;
    if (dmem_req_o) begin
      if (!mem_busy) begin
        if (exp_load_q.size() == 0) begin
          fail_run("Data request raised while no load was outstanding");
        end
        check_value("dmem_req_o for load", 1, exp_load_q[0]);
        check_value("dmem_addr_o", exp_addr_q[0], dmem_addr_o);
        mem_busy = 1'b1;
        mem_wait = $random(seed) & 3;
      end
      if (mem_wait == 0) begin
        dmem_rvalid_i = 1'b1;
        dmem_rdata_i  = mem_data(dmem_addr_o);
        mem_busy      = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  endtask

  task automatic check_retire();
    logic [RADDR_W-1:0] rd;
    logic [XLEN-1:0]    data;
    logic               is_load;
    int                 acc;
    if (exp_rd_q.size() == 0) begin
      fail_run("Retirement seen with no instruction outstanding");
    end
    rd      = exp_rd_q.pop_front();
    data    = exp_data_q.pop_front();
    is_load = exp_load_q.pop_front();
    acc     = exp_cycle_q.pop_front();
    void'(exp_addr_q.pop_front());
    check_value("retire_rd_o", rd, retire_rd_o);
    check_value("retire_data_o", data, retire_data_o);
    // Two cycles from accept when nothing waited on memory
    if (!is_load && (last_bp_cycle < acc)) begin
      check_value("retire latency", 2, cycle - acc);
    end
    n_retired++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers and monitor
  //////////////////////////////////////////////////////////////////////

  // Inputs change 1 unit after the rising edge
  always begin
    @(posedge clk_i);
    #1;
    if (run) begin
      respond_memory();
      if (!instr_valid_i || xfer_seen) begin
        if ((n_gen < NUM_INSTR) && (($random(seed) & 3) != 0)) begin
          build_instr(next_instr);
          instr_i       = next_instr;
          instr_valid_i = 1'b1;
          n_gen++;
        end else begin
          instr_valid_i = 1'b0;
        end
      end
    end
  end

  // Sampled mid-cycle where all outputs are settled
  always @(negedge clk_i) begin
    cycle++;
    if (cycle > MAX_CYCLES) begin
      fail_run("Timeout: retirement stalled before all instructions retired");
    end
    if (!arst_n_i) begin
      check_value("retire_valid_o", 0, retire_valid_o);
      check_value("dmem_req_o", 0, dmem_req_o);
      check_value("instr_ready_o", 1, instr_ready_o);
    end
    // Load waiting on memory holds back retirement
    if (dmem_req_o && !dmem_rvalid_i) begin
      last_bp_cycle = cycle;
      check_value("retire_valid_o", 0, retire_valid_o);
    end
    if (retire_valid_o) begin
      check_retire();
    end
    xfer_seen = instr_valid_i && instr_ready_o;
    if (xfer_seen) begin
      accept_instr(instr_i, cycle);
      n_accepted++;
    end
  end

  initial begin
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    dmem_rvalid_i = 1'b0;
    dmem_rdata_i  = '0;
    run           = 1'b0;
    xfer_seen     = 1'b0;
    mem_busy      = 1'b0;
    mem_wait      = 0;
    cycle         = 0;
    last_bp_cycle = -1;
    n_gen         = 0;
    n_accepted    = 0;
    n_retired     = 0;
    clear_arch_state();
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // Empty pipe right after reset
    @(negedge clk_i);
    check_value("instr_ready_o", 1, instr_ready_o);
    check_value("dmem_req_o", 0, dmem_req_o);
    check_value("retire_valid_o", 0, retire_valid_o);
    run = 1'b1;
    while (n_retired < NUM_INSTR) begin
      @(negedge clk_i);
    end
    // Drain so that an extra retirement would show up
    repeat (8) @(negedge clk_i);
    if ((n_accepted != n_retired) || (exp_rd_q.size() != 0)) begin
      fail_run($sformatf("Accepted %0d instructions but retired %0d", n_accepted, n_retired));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
// Single-cycle ALU; arithmetic wraps at XLEN bits and NOP yields zero
`default_nettype none

module ex_stage (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // ID/EX register
  input  logic                         ex_valid_i,
  input  pipe_pkg::op_e                ex_op_i,
  input  logic [pipe_pkg::RADDR_W-1:0] ex_rd_i,
  input  logic [pipe_pkg::XLEN-1:0]    ex_opa_i,
  input  logic [pipe_pkg::XLEN-1:0]    ex_opb_i,
  input  logic                         wb_ready_i,
  // To hazard unit and ID forwarding
  output logic                         ex_we_o,
  output logic                         ex_load_o,
  output logic [pipe_pkg::XLEN-1:0]    ex_result_o,
  // EX/WB register
  output logic                         wb_valid_o,
  output pipe_pkg::op_e                wb_op_o,
  output logic [pipe_pkg::RADDR_W-1:0] wb_rd_o,
  output logic [pipe_pkg::XLEN-1:0]    wb_value_o
);
  import pipe_pkg::*;

  always_comb begin
    case (ex_op_i)
      OP_SUB:  ex_result_o = ex_opa_i - ex_opb_i;
      OP_NOP:  ex_result_o = '0;
      // ADD and load address share the adder
      default: ex_result_o = ex_opa_i + ex_opb_i;
    endcase
  end

  // Every op except NOP targets rd
  assign ex_we_o   = (ex_op_i != OP_NOP);
  assign ex_load_o = ex_valid_i && (ex_op_i == OP_LOAD);

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      wb_valid_o <= ex_valid_i;
    end
  end

  // Payload only moves with a real instruction
  always_ff @(posedge clk_i) begin
    if (wb_ready_i && ex_valid_i) begin
      wb_op_o    <= ex_op_i;
      wb_rd_o    <= ex_rd_i;
      wb_value_o <= ex_result_o;
    end
  end

endmodule

`default_nettype wire

//--- hw/hazard_bypass.sv
// Purely combinational; read enables from ID are expected to be qualified with ID valid
`default_nettype none

module hazard_bypass (
  // From ID
  input  logic [pipe_pkg::RADDR_W-1:0] rs1_i,
  input  logic [pipe_pkg::RADDR_W-1:0] rs2_i,
  input  logic [1:0]                   re_i,
  input  logic                         id_valid_i,
  // From EX
  input  logic                         ex_valid_i,
  input  logic                         ex_we_i,
  input  logic [pipe_pkg::RADDR_W-1:0] ex_rd_i,
  input  logic                         ex_load_i,
  // From WB
  input  logic                         wb_valid_i,
  input  logic                         wb_we_i,
  input  logic [pipe_pkg::RADDR_W-1:0] wb_rd_i,
  input  logic                         wb_load_i,
  input  logic                         wb_ready_i,
  // To ID
  output logic                         load_stall_o,
  output pipe_pkg::fw_sel_e            fw_a_sel_o,
  output pipe_pkg::fw_sel_e            fw_b_sel_o
);
  import pipe_pkg::*;

  logic [RADDR_W-1:0] raddr [2];
  logic [1:0]         ex_match;
  logic [1:0]         wb_match;
  logic               ex_wr;
  logic               wb_wr;

  // Stage writes a register only when it holds a real instruction
  assign ex_wr = ex_valid_i && ex_we_i;
  assign wb_wr = wb_valid_i && wb_we_i;

  assign raddr[0] = rs1_i;
  assign raddr[1] = rs2_i;

  for (genvar i = 0; i < 2; i++) begin : gen_match
    // Address match per read port, r0 never matches
    assign ex_match[i] = ex_wr && re_i[i] && |raddr[i] && (ex_rd_i == raddr[i]);
    assign wb_match[i] = wb_wr && re_i[i] && |raddr[i] && (wb_rd_i == raddr[i]);
  end

  //////////////////////////////////////////////////////////////////////
  // Load-use stall
  //////////////////////////////////////////////////////////////////////

  // EX load has no data yet
  // WB load still waiting on memory
  assign load_stall_o = (ex_load_i && |ex_match) ||
                        (wb_load_i && !wb_ready_i && |wb_match);

  //////////////////////////////////////////////////////////////////////
  // Forwarding select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_a_sel_o = FW_RF;
    fw_b_sel_o = FW_RF;

    // Older result first
    if (wb_match[0]) begin
      fw_a_sel_o = FW_WB;
    end
    if (wb_match[1]) begin
      fw_b_sel_o = FW_WB;
    end

    // Younger result wins
    if (ex_match[0]) begin
      fw_a_sel_o = FW_EX;
    end
    if (ex_match[1]) begin
      fw_b_sel_o = FW_EX;
    end
  end

  // Stall must only hold back a real ID instruction
  a_stall_needs_id: assert final (load_stall_o !== 1'b1 || id_valid_i === 1'b1)
    else $error("load stall raised with no valid instruction in ID");

endmodule

`default_nettype wire

//--- hw/id_stage.sv
// ID holds the instruction on the input stream; the sender keeps it stable until ready
`default_nettype none

module id_stage (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Instruction stream
  input  logic                         instr_valid_i,
  input  logic [pipe_pkg::INSTR_W-1:0] instr_i,
  output logic                         instr_ready_o,
  // Hazard unit
  input  logic                         load_stall_i,
  input  pipe_pkg::fw_sel_e            fw_a_sel_i,
  input  pipe_pkg::fw_sel_e            fw_b_sel_i,
  output logic [pipe_pkg::RADDR_W-1:0] rs1_o,
  output logic [pipe_pkg::RADDR_W-1:0] rs2_o,
  output logic [1:0]                   re_o,
  output logic                         id_valid_o,
  // Operand sources
  input  logic [pipe_pkg::XLEN-1:0]    rf_rdata_a_i,
  input  logic [pipe_pkg::XLEN-1:0]    rf_rdata_b_i,
  input  logic [pipe_pkg::XLEN-1:0]    ex_result_i,
  input  logic [pipe_pkg::XLEN-1:0]    wb_wdata_i,
  input  logic                         wb_ready_i,
  // ID/EX register
  output logic                         ex_valid_o,
  output pipe_pkg::op_e                ex_op_o,
  output logic [pipe_pkg::RADDR_W-1:0] ex_rd_o,
  output logic [pipe_pkg::XLEN-1:0]    ex_opa_o,
  output logic [pipe_pkg::XLEN-1:0]    ex_opb_o
);
  import pipe_pkg::*;

  op_e                        id_op;
  logic [RADDR_W-1:0]         id_rd;
  logic [RS2_LSB-IMM_LSB-1:0] id_imm;
  logic [XLEN-1:0]            opa;
  logic [XLEN-1:0]            fw_b;
  logic [XLEN-1:0]            opb;
  logic                       issue;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign id_op  = op_e'(instr_i[OP_LSB +: 2]);
  assign id_rd  = instr_i[RD_LSB +: RADDR_W];
  assign rs1_o  = instr_i[RS1_LSB +: RADDR_W];
  assign rs2_o  = instr_i[RS2_LSB +: RADDR_W];
  assign id_imm = instr_i[IMM_LSB +: (RS2_LSB - IMM_LSB)];

  assign id_valid_o = instr_valid_i;
  // rs1 for everything but NOP, rs2 only for ALU ops
  assign re_o[0] = instr_valid_i && (id_op != OP_NOP);
  assign re_o[1] = instr_valid_i && ((id_op == OP_ADD) || (id_op == OP_SUB));

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fw_a_sel_i)
      FW_EX:   opa = ex_result_i;
      FW_WB:   opa = wb_wdata_i;
      default: opa = rf_rdata_a_i;
    endcase
    case (fw_b_sel_i)
      FW_EX:   fw_b = ex_result_i;
      FW_WB:   fw_b = wb_wdata_i;
      default: fw_b = rf_rdata_b_i;
    endcase
  end

  // Load uses imm as the offset
  assign opb = (id_op == OP_LOAD) ? XLEN'(id_imm) : fw_b;

  //////////////////////////////////////////////////////////////////////
  // Handshake and ID/EX register
  //////////////////////////////////////////////////////////////////////

  assign instr_ready_o = wb_ready_i && !load_stall_i;
  assign issue         = instr_valid_i && instr_ready_o;

  // Bubble on stall or empty input, hold while WB waits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      ex_valid_o <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      ex_op_o  <= id_op;
      ex_rd_o  <= id_rd;
      ex_opa_o <= opa;
      ex_opb_o <= opb;
    end
  end

  // Back-pressure from WB freezes EX
  a_idex_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !wb_ready_i |=> $stable({ex_valid_o, ex_op_o, ex_rd_o, ex_opa_o, ex_opb_o}))
    else $error("ID/EX register changed while WB was not ready");

endmodule

`default_nettype wire

//--- hw/pipe_pkg.sv
// 16-bit instruction word with fixed field positions; imm is zero-extended and r0 is hardwired
`default_nettype none

package pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN    = 16;
  localparam int unsigned NREGS   = 8;
  localparam int unsigned RADDR_W = 3;
  localparam int unsigned INSTR_W = 16;

  //////////////////////////////////////////////////////////////////////
  // Instruction format
  //////////////////////////////////////////////////////////////////////

  // Opcode in [15:14]
  localparam int unsigned OP_LSB  = 14;
  // Destination in [13:11]
  localparam int unsigned RD_LSB  = 11;
  // Sources in [10:8] and [7:5]
  localparam int unsigned RS1_LSB = 8;
  localparam int unsigned RS2_LSB = 5;
  // Immediate fills the low bits up to rs2
  localparam int unsigned IMM_LSB = 0;

  typedef enum logic [1:0] {
    OP_NOP  = 2'b00,
    OP_ADD  = 2'b01,
    OP_SUB  = 2'b10,
    OP_LOAD = 2'b11
  } op_e;

  // Operand source for the ID muxes
  typedef enum logic [1:0] {
    FW_RF = 2'b00,
    FW_EX = 2'b01,
    FW_WB = 2'b10
  } fw_sel_e;

endpackage

`default_nettype wire

//--- hw/pipe_regfile.sv
// Two async read ports, one write port; r0 reads zero and writes to it are dropped
`default_nettype none

module pipe_regfile (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [pipe_pkg::RADDR_W-1:0] raddr_a_i,
  input  logic [pipe_pkg::RADDR_W-1:0] raddr_b_i,
  output logic [pipe_pkg::XLEN-1:0]    rdata_a_o,
  output logic [pipe_pkg::XLEN-1:0]    rdata_b_o,
  input  logic                         we_i,
  input  logic [pipe_pkg::RADDR_W-1:0] waddr_i,
  input  logic [pipe_pkg::XLEN-1:0]    wdata_i
);
  import pipe_pkg::*;

  // Storage for r1..r7 only
  logic [XLEN-1:0] regs_q [1:NREGS-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // r0 muxed to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // A nonzero write is visible on port a one cycle later
  a_rf_write_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (we_i && (waddr_i != '0)) ##1 (raddr_a_i == $past(waddr_i))
      |-> (rdata_a_o == $past(wdata_i)))
    else $error("regfile write of r%0d not visible on next read", $past(waddr_i));

endmodule

`default_nettype wire

//--- hw/pipe_top.sv
// Instruction stream must hold valid and data stable until accepted
`default_nettype none

module pipe_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Instruction stream
  input  logic                         instr_valid_i,
  input  logic [pipe_pkg::INSTR_W-1:0] instr_i,
  output logic                         instr_ready_o,
  // Data port
  output logic                         dmem_req_o,
  output logic [pipe_pkg::XLEN-1:0]    dmem_addr_o,
  input  logic                         dmem_rvalid_i,
  input  logic [pipe_pkg::XLEN-1:0]    dmem_rdata_i,
  // Retire port
  output logic                         retire_valid_o,
  output logic [pipe_pkg::RADDR_W-1:0] retire_rd_o,
  output logic [pipe_pkg::XLEN-1:0]    retire_data_o
);
  import pipe_pkg::*;

  // ID side
  logic [RADDR_W-1:0] rs1, rs2;
  logic [1:0]         re;
  logic               id_valid;
  logic               load_stall;
  fw_sel_e            fw_a_sel, fw_b_sel;
  logic [XLEN-1:0]    rf_rdata_a, rf_rdata_b;

  // ID/EX register
  logic               ex_valid;
  op_e                ex_op;
  logic [RADDR_W-1:0] ex_rd;
  logic [XLEN-1:0]    ex_opa, ex_opb;
  logic               ex_we, ex_load;
  logic [XLEN-1:0]    ex_result;

  // EX/WB register and WB outputs
  logic               wb_valid;
  op_e                wb_op;
  logic [RADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]    wb_value;
  logic               wb_ready, wb_we, wb_load;
  logic [XLEN-1:0]    wb_wdata;
  logic               rf_we;
  logic [RADDR_W-1:0] rf_waddr;

  id_stage u_id_stage (
    .clk_i, .arst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
    .load_stall_i (load_stall), .fw_a_sel_i (fw_a_sel), .fw_b_sel_i (fw_b_sel),
    .rs1_o (rs1), .rs2_o (rs2), .re_o (re), .id_valid_o (id_valid),
    .rf_rdata_a_i (rf_rdata_a), .rf_rdata_b_i (rf_rdata_b),
    .ex_result_i (ex_result), .wb_wdata_i (wb_wdata), .wb_ready_i (wb_ready),
    .ex_valid_o (ex_valid), .ex_op_o (ex_op), .ex_rd_o (ex_rd),
    .ex_opa_o (ex_opa), .ex_opb_o (ex_opb)
  );

  hazard_bypass u_hazard_bypass (
    .rs1_i (rs1), .rs2_i (rs2), .re_i (re), .id_valid_i (id_valid),
    .ex_valid_i (ex_valid), .ex_we_i (ex_we), .ex_rd_i (ex_rd), .ex_load_i (ex_load),
    .wb_valid_i (wb_valid), .wb_we_i (wb_we), .wb_rd_i (wb_rd), .wb_load_i (wb_load),
    .wb_ready_i (wb_ready),
    .load_stall_o (load_stall), .fw_a_sel_o (fw_a_sel), .fw_b_sel_o (fw_b_sel)
  );

  pipe_regfile u_pipe_regfile (
    .clk_i, .arst_n_i,
    .raddr_a_i (rs1), .raddr_b_i (rs2),
    .rdata_a_o (rf_rdata_a), .rdata_b_o (rf_rdata_b),
    .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (wb_wdata)
  );

  ex_stage u_ex_stage (
    .clk_i, .arst_n_i,
    .ex_valid_i (ex_valid), .ex_op_i (ex_op), .ex_rd_i (ex_rd),
    .ex_opa_i (ex_opa), .ex_opb_i (ex_opb), .wb_ready_i (wb_ready),
    .ex_we_o (ex_we), .ex_load_o (ex_load), .ex_result_o (ex_result),
    .wb_valid_o (wb_valid), .wb_op_o (wb_op), .wb_rd_o (wb_rd), .wb_value_o (wb_value)
  );

  wb_stage u_wb_stage (
    .wb_valid_i (wb_valid), .wb_op_i (wb_op), .wb_rd_i (wb_rd), .wb_value_i (wb_value),
    .dmem_req_o, .dmem_addr_o, .dmem_rvalid_i, .dmem_rdata_i,
    .wb_ready_o (wb_ready), .wb_we_o (wb_we), .wb_load_o (wb_load),
    .wb_wdata_o (wb_wdata), .rf_we_o (rf_we), .rf_waddr_o (rf_waddr),
    .retire_valid_o, .retire_rd_o, .retire_data_o
  );

endmodule

`default_nettype wire

//--- hw/wb_stage.sv
// Load request held until rvalid; memory must answer each load with exactly one rvalid
`default_nettype none

module wb_stage (
  // EX/WB register
  input  logic                         wb_valid_i,
  input  pipe_pkg::op_e                wb_op_i,
  input  logic [pipe_pkg::RADDR_W-1:0] wb_rd_i,
  input  logic [pipe_pkg::XLEN-1:0]    wb_value_i,
  // Data port
  output logic                         dmem_req_o,
  output logic [pipe_pkg::XLEN-1:0]    dmem_addr_o,
  input  logic                         dmem_rvalid_i,
  input  logic [pipe_pkg::XLEN-1:0]    dmem_rdata_i,
  // To hazard unit and ID
  output logic                         wb_ready_o,
  output logic                         wb_we_o,
  output logic                         wb_load_o,
  output logic [pipe_pkg::XLEN-1:0]    wb_wdata_o,
  // Register file write
  output logic                         rf_we_o,
  output logic [pipe_pkg::RADDR_W-1:0] rf_waddr_o,
  // Retire port
  output logic                         retire_valid_o,
  output logic [pipe_pkg::RADDR_W-1:0] retire_rd_o,
  output logic [pipe_pkg::XLEN-1:0]    retire_data_o
);
  import pipe_pkg::*;

  logic is_nop;

  assign is_nop    = (wb_op_i == OP_NOP);
  assign wb_load_o = wb_valid_i && (wb_op_i == OP_LOAD);
  assign wb_we_o   = !is_nop;

  // Address comes straight from the EX adder result
  assign dmem_req_o  = wb_load_o;
  assign dmem_addr_o = wb_value_i;

  // Only a load without data holds the pipe
  assign wb_ready_o = !wb_load_o || dmem_rvalid_i;
  assign wb_wdata_o = wb_load_o ? dmem_rdata_i : wb_value_i;

  // r0 filtering happens in the register file
  assign rf_we_o    = wb_valid_i && wb_we_o && wb_ready_o;
  assign rf_waddr_o = wb_rd_i;

  // NOPs retire too, with rd and data zeroed
  assign retire_valid_o = wb_valid_i && wb_ready_o;
  assign retire_rd_o    = is_nop ? '0 : wb_rd_i;
  assign retire_data_o  = is_nop ? '0 : wb_wdata_o;

  // A response never arrives without an open request
  a_rvalid_needs_req: assert property (@(posedge dmem_rvalid_i) dmem_req_o)
    else $error("dmem_rvalid_i raised with no load request pending");

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
hw/pipe_pkg.sv
hw/pipe_regfile.sv
hw/hazard_bypass.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/wb_stage.sv
hw/pipe_top.sv
bench/pipe_tb.sv
